// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Geometry and register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MMIO_SELECT_BIT = 11;
    localparam int LANE_ADDR_WIDTH = 9;

    typedef logic [31:0]                addr_t;
    typedef logic [31:0]                word_t;
    typedef logic [LANE_ADDR_WIDTH-1:0] lane_addr_t;
    typedef logic [3:0]                 lane_we_t;
    typedef logic [2:0]                 mem_op_t;

    // Byte offsets inside the register block
    localparam addr_t SEG_OFFSET         = 32'h0;
    localparam addr_t UART_DATA_OFFSET   = 32'h4;
    localparam addr_t UART_STATUS_OFFSET = 32'h8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operations and control words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam mem_op_t OP_LB  = 3'd0;
    localparam mem_op_t OP_LBU = 3'd1;
    localparam mem_op_t OP_LH  = 3'd2;
    localparam mem_op_t OP_LHU = 3'd3;
    localparam mem_op_t OP_LW  = 3'd4;
    localparam mem_op_t OP_SB  = 3'd5;
    localparam mem_op_t OP_SH  = 3'd6;
    localparam mem_op_t OP_SW  = 3'd7;

    typedef struct packed {
        logic    valid;
        mem_op_t op;
        logic    is_mmio;
    } stage_ctl_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        SETTLE,
        DONE
    } seq_state_t;

    function automatic logic op_is_store(input mem_op_t op);
        return op >= OP_SB;
    endfunction

    // Lanes touched by a store at offset zero
    function automatic lane_we_t op_size_mask(input mem_op_t op);
        case (op)
            OP_SB:   return 4'b0001;
            OP_SH:   return 4'b0011;
            OP_SW:   return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: lane_bus_if.sv
`default_nettype none

interface lane_bus_if #(
    parameter int ADDR_WIDTH = mem_pkg::LANE_ADDR_WIDTH
) ();
    import mem_pkg::*;

    lane_we_t                   we;
    logic [3:0][ADDR_WIDTH-1:0] addr;
    word_t                      wdata;
    word_t                      rdata;

    modport encoder (
        output we,
        output addr,
        output wdata
    );

    modport ram (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

    modport decoder (
        input rdata
    );

endinterface

`default_nettype wire

// File: mem_sequencer.sv
`default_nettype none

module mem_sequencer #(
    parameter int MMIO_SELECT_BIT = mem_pkg::MMIO_SELECT_BIT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  mem_pkg::mem_op_t    op,
    input  mem_pkg::addr_t      addr,
    output logic                ack,
    output mem_pkg::stage_ctl_t ctl_s2,
    output mem_pkg::stage_ctl_t ctl_s3
);
    import mem_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    // One request walks IDLE, ACCESS, SETTLE, DONE, one state per edge
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_next = ACCESS;
                end
            end
            ACCESS: state_next = SETTLE;
            SETTLE: state_next = DONE;
            DONE: begin
                if (!req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            ack    <= 1'b0;
            ctl_s2 <= '0;
            ctl_s3 <= '0;
        end else begin
            state <= state_next;
            // Raised one edge into DONE and dropped on the edge that sees req low
            ack <= (state == DONE) && req;

            if (state == IDLE && req) begin
                ctl_s2.valid   <= 1'b1;
                ctl_s2.op      <= op;
                ctl_s2.is_mmio <= addr[MMIO_SELECT_BIT];
            end else begin
                ctl_s2.valid <= 1'b0;
            end

            // Stage 2 word moves on unchanged, so stage 3 is valid only in SETTLE
            ctl_s3 <= ctl_s2;
        end
    end

    // The request must have been held through the whole access before ack rises
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req) && $past(req, 3)
    ) else $error("ack rose without a held request");

endmodule

`default_nettype wire

// File: lane_encoder.sv
`default_nettype none

module lane_encoder #(
    parameter int LANE_ADDR_WIDTH = mem_pkg::LANE_ADDR_WIDTH
) (
    input  mem_pkg::stage_ctl_t ctl_s2,
    input  mem_pkg::addr_t      addr,
    input  mem_pkg::word_t      wdata,
    lane_bus_if.encoder         lanes
);
    import mem_pkg::*;

    logic [1:0]                 offset;
    logic [LANE_ADDR_WIDTH-1:0] word_addr;
    logic [LANE_ADDR_WIDTH-1:0] next_word_addr;
    lane_we_t                   size_mask;
    logic                       write_ram;

    assign offset         = addr[1:0];
    assign word_addr      = addr[LANE_ADDR_WIDTH+1:2];
    assign next_word_addr = word_addr + 1'b1;
    assign size_mask      = op_size_mask(ctl_s2.op);
    assign write_ram      = ctl_s2.valid && op_is_store(ctl_s2.op) && !ctl_s2.is_mmio;

    // Byte k of the store lands on lane (k + offset) mod 4. Lanes below the
    // offset hold the bytes that spill into the following word
    always_comb begin
        logic [1:0] src;

        src = '0;
        for (int i = 0; i < 4; i++) begin
            src = 2'(i) - offset;
            lanes.addr[i]         = (2'(i) < offset) ? next_word_addr : word_addr;
            lanes.wdata[8*i +: 8] = wdata[8*src +: 8];
            lanes.we[i]           = write_ram && size_mask[src];
        end
    end

endmodule

`default_nettype wire

// File: byte_lane_ram.sv
`default_nettype none

module byte_lane_ram #(
    parameter int LANE_ADDR_WIDTH = mem_pkg::LANE_ADDR_WIDTH
) (
    input  logic    clk,
    lane_bus_if.ram lanes
);

    localparam int DEPTH = 2 ** LANE_ADDR_WIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One byte-wide array per lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [7:0] mem [DEPTH];
        logic [7:0] q;

        // Read returns the old byte when the same word is written
        always_ff @(posedge clk) begin
            if (lanes.we[i]) begin
                mem[lanes.addr[i]] <= lanes.wdata[8*i +: 8];
            end
            q <= mem[lanes.addr[i]];
        end

        assign lanes.rdata[8*i +: 8] = q;
    end

endmodule

`default_nettype wire

// File: load_decoder.sv
`default_nettype none

module load_decoder (
    input  mem_pkg::stage_ctl_t ctl_s3,
    input  logic [1:0]          addr_align,
    lane_bus_if.decoder         lanes,
    output mem_pkg::word_t      load_data
);
    import mem_pkg::*;

    word_t aligned;

    // Undo the store rotation, byte j comes from lane (j + offset) mod 4
    always_comb begin
        logic [1:0] src;

        src = '0;
        for (int j = 0; j < 4; j++) begin
            src = 2'(j) + addr_align;
            aligned[8*j +: 8] = lanes.rdata[8*src +: 8];
        end
    end

    always_comb begin
        case (ctl_s3.op)
            OP_LB: begin
                load_data = {{24{aligned[7]}}, aligned[7:0]};
            end
            OP_LBU: begin
                load_data = {24'h0, aligned[7:0]};
            end
            OP_LH: begin
                load_data = {{16{aligned[15]}}, aligned[15:0]};
            end
            OP_LHU: begin
                load_data = {16'h0, aligned[15:0]};
            end
            default: begin
                // Word loads, stores just see the aligned word
                load_data = aligned;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mmio_regs.sv
`default_nettype none

module mmio_regs #(
    parameter int MMIO_SELECT_BIT = mem_pkg::MMIO_SELECT_BIT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::stage_ctl_t ctl_s2,
    input  mem_pkg::addr_t      addr,
    input  mem_pkg::word_t      wdata,
    input  logic                uart_tx_sending,
    output mem_pkg::word_t      read_data,
    output logic [15:0]         seven_segment,
    output logic [8:0]          uart_tx_data
);
    import mem_pkg::*;

    logic [MMIO_SELECT_BIT-1:0] reg_offset;
    addr_t                      reg_sel;
    logic                       access;
    logic                       write;

    assign reg_offset = addr[MMIO_SELECT_BIT-1:0];
    assign reg_sel    = addr_t'(reg_offset);
    assign access     = ctl_s2.valid && ctl_s2.is_mmio;
    assign write      = access && op_is_store(ctl_s2.op);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seven_segment <= '0;
            uart_tx_data  <= '0;
        end else if (write) begin
            if (reg_sel == SEG_OFFSET) begin
                seven_segment <= wdata[15:0];
            end
            // A character already on its way out is not overwritten
            if (reg_sel == UART_DATA_OFFSET && !uart_tx_sending) begin
                uart_tx_data <= wdata[8:0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read value for stage 3
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                SEG_OFFSET:         read_data <= {16'h0, seven_segment};
                UART_DATA_OFFSET:   read_data <= {23'h0, uart_tx_data};
                UART_STATUS_OFFSET: read_data <= {31'h0, uart_tx_sending};
                default:            read_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: memory_system.sv
`default_nettype none

module memory_system #(
    parameter int MMIO_SELECT_BIT = mem_pkg::MMIO_SELECT_BIT,
    parameter int LANE_ADDR_WIDTH = mem_pkg::LANE_ADDR_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  mem_pkg::mem_op_t op,
    input  mem_pkg::addr_t   addr,
    input  mem_pkg::word_t   wdata,
    input  logic             uart_tx_sending,
    output logic             ack,
    output mem_pkg::word_t   rdata,
    output logic [15:0]      seven_segment,
    output logic [8:0]       uart_tx_data
);
    import mem_pkg::*;

    stage_ctl_t ctl_s2;
    stage_ctl_t ctl_s3;
    word_t      load_data;
    word_t      mmio_data;
    logic [1:0] addr_align;

    lane_bus_if #(.ADDR_WIDTH(LANE_ADDR_WIDTH)) lanes ();

    mem_sequencer #(.MMIO_SELECT_BIT(MMIO_SELECT_BIT)) mem_sequencer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .op     (op),
        .addr   (addr),
        .ack    (ack),
        .ctl_s2 (ctl_s2),
        .ctl_s3 (ctl_s3)
    );

    lane_encoder #(.LANE_ADDR_WIDTH(LANE_ADDR_WIDTH)) lane_encoder_inst (
        .ctl_s2 (ctl_s2),
        .addr   (addr),
        .wdata  (wdata),
        .lanes  (lanes.encoder)
    );

    byte_lane_ram #(.LANE_ADDR_WIDTH(LANE_ADDR_WIDTH)) byte_lane_ram_inst (
        .clk   (clk),
        .lanes (lanes.ram)
    );

    load_decoder load_decoder_inst (
        .ctl_s3     (ctl_s3),
        .addr_align (addr_align),
        .lanes      (lanes.decoder),
        .load_data  (load_data)
    );

    mmio_regs #(.MMIO_SELECT_BIT(MMIO_SELECT_BIT)) mmio_regs_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctl_s2          (ctl_s2),
        .addr            (addr),
        .wdata           (wdata),
        .uart_tx_sending (uart_tx_sending),
        .read_data       (mmio_data),
        .seven_segment   (seven_segment),
        .uart_tx_data    (uart_tx_data)
    );

    // Offset travels with the RAM read into stage 3
    always_ff @(posedge clk) begin
        if (ctl_s2.valid) begin
            addr_align <= addr[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_s3.valid) begin
            rdata <= ctl_s3.is_mmio ? mmio_data : load_data;
        end
    end

    rdata_held_under_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(rdata)
    ) else $error("rdata changed while ack was high");

endmodule

`default_nettype wire

// File: tb_memory_system.sv
`default_nettype none

module tb_memory_system;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int    ACK_TIMEOUT = 40;
    localparam addr_t MMIO_BASE   = 32'h800;

    typedef struct {
        mem_op_t     op;
        addr_t       addr;
        word_t       wdata;
        logic        busy;
        logic        chk_rd;
        word_t       exp_rd;
        logic [15:0] exp_seg;
        logic [8:0]  exp_uart;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    mem_op_t     op;
    addr_t       addr;
    word_t       wdata;
    logic        uart_tx_sending;
    logic        ack;
    word_t       rdata;
    logic [15:0] seven_segment;
    logic [8:0]  uart_tx_data;

    // Reference model of the RAM bytes and the two writable registers
    logic [7:0]  model_mem [2048];
    logic [15:0] model_seg;
    logic [8:0]  model_uart;
    row_t        table_q [$];
    int          errors;

    memory_system memory_system_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .op              (op),
        .addr            (addr),
        .wdata           (wdata),
        .uart_tx_sending (uart_tx_sending),
        .ack             (ack),
        .rdata           (rdata),
        .seven_segment   (seven_segment),
        .uart_tx_data    (uart_tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_segment(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH seven_segment: got 0x%04h expected 0x%04h",
                                      got, exp));
        end
    endtask

    task automatic check_uart(input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH uart_tx_data: got 0x%03h expected 0x%03h",
                                      got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int op_size(input mem_op_t o);
        case (o)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_t o);
        return o == OP_SB || o == OP_SH || o == OP_SW;
    endfunction

    // RAM bytes wrap inside the 2 KiB window
    function automatic int byte_index(input addr_t a, input int k);
        return int'((a + addr_t'(k)) & 32'h7ff);
    endfunction

    function automatic word_t model_read(input mem_op_t o, input addr_t a);
        word_t raw;
        raw = '0;
        for (int k = 0; k < op_size(o); k++) begin
            raw[8*k +: 8] = model_mem[byte_index(a, k)];
        end
        case (o)
            OP_LB:   return {{24{raw[7]}}, raw[7:0]};
            OP_LH:   return {{16{raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic void add_row(input mem_op_t o, input addr_t a, input word_t d,
                                    input logic busy);
        row_t  r;
        addr_t reg_off;
        r.op     = o;
        r.addr   = a;
        r.wdata  = d;
        r.busy   = busy;
        r.chk_rd = !is_store(o);
        r.exp_rd = '0;
        reg_off  = a & 32'h7ff;
        if (a[11]) begin
            if (is_store(o)) begin
                if (reg_off == SEG_OFFSET) model_seg = d[15:0];
                if (reg_off == UART_DATA_OFFSET && !busy) model_uart = d[8:0];
            end else if (reg_off == SEG_OFFSET) begin
                r.exp_rd = {16'h0, model_seg};
            end else if (reg_off == UART_DATA_OFFSET) begin
                r.exp_rd = {23'h0, model_uart};
            end else if (reg_off == UART_STATUS_OFFSET) begin
                r.exp_rd = {31'h0, busy};
            end
        end else if (is_store(o)) begin
            for (int k = 0; k < op_size(o); k++) begin
                model_mem[byte_index(a, k)] = d[8*k +: 8];
            end
        end else begin
            r.exp_rd = model_read(o, a);
        end
        r.exp_seg  = model_seg;
        r.exp_uart = model_uart;
        table_q.push_back(r);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entered and left 2 ns after a rising edge
    task automatic run_request(input row_t r);
        int    waited;
        word_t held;
        op              = r.op;
        addr            = r.addr;
        wdata           = r.wdata;
        uart_tx_sending = r.busy;
        req             = 1'b1;
        waited          = 0;
        while (!ack) begin
            if (waited >= ACK_TIMEOUT) stop_with_error("timeout waiting for ack to rise");
            @(posedge clk);
            #2;
            waited++;
        end
        if (r.chk_rd) check_word("rdata", rdata, r.exp_rd);
        held = rdata;
        // Holding req one more cycle keeps ack and rdata where they are
        @(posedge clk);
        #2;
        if (!ack) stop_with_error("ack fell while req was still high");
        check_word("rdata", rdata, held);
        req    = 1'b0;
        waited = 0;
        while (ack) begin
            if (waited >= ACK_TIMEOUT) stop_with_error("timeout waiting for ack to fall");
            @(posedge clk);
            #2;
            waited++;
        end
        uart_tx_sending = 1'b0;
        check_segment(seven_segment, r.exp_seg);
        check_uart(uart_tx_data, r.exp_uart);
    endtask

    initial begin
        addr_t a;
        errors          = 0;
        void'($urandom(32'he865));
        rst_n           = 1'b0;
        req             = 1'b0;
        op              = OP_LW;
        addr            = '0;
        wdata           = '0;
        uart_tx_sending = 1'b0;
        model_seg       = '0;
        model_uart      = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (ack !== 1'b0) stop_with_error("ack is not low after reset");
        check_segment(seven_segment, 16'h0);
        check_uart(uart_tx_data, 9'h0);

        // Aligned words with random data
        for (int w = 0; w < 16; w++) add_row(OP_SW, addr_t'(4 * w), $urandom(), 1'b0);
        for (int w = 0; w < 16; w++) add_row(OP_LW, addr_t'(4 * w), '0, 1'b0);
        for (int n = 0; n < 8; n++) begin
            a = addr_t'($urandom_range(64, 511)) << 2;
            add_row(OP_SW, a, $urandom(), 1'b0);
            add_row(OP_LW, a, '0, 1'b0);
        end

        // Byte and halfword merges with sign and zero extension
        add_row(OP_SB, 32'h005, 32'h0000_0080, 1'b0);
        add_row(OP_SH, 32'h00a, 32'h1234_8001, 1'b0);
        add_row(OP_SB, 32'h00f, 32'h0000_007f, 1'b0);
        add_row(OP_LW, 32'h004, '0, 1'b0);
        add_row(OP_LW, 32'h008, '0, 1'b0);
        add_row(OP_LW, 32'h00c, '0, 1'b0);
        add_row(OP_LB, 32'h005, '0, 1'b0);
        add_row(OP_LBU, 32'h005, '0, 1'b0);
        add_row(OP_LH, 32'h00a, '0, 1'b0);
        add_row(OP_LHU, 32'h00a, '0, 1'b0);
        add_row(OP_LB, 32'h00f, '0, 1'b0);
        add_row(OP_LBU, 32'h00e, '0, 1'b0);

        // Unaligned accesses, some crossing a word boundary
        add_row(OP_SW, 32'h011, 32'ha1b2_c3d4, 1'b0);
        add_row(OP_LW, 32'h011, '0, 1'b0);
        add_row(OP_LW, 32'h010, '0, 1'b0);
        add_row(OP_LW, 32'h014, '0, 1'b0);
        add_row(OP_SH, 32'h017, 32'h0000_5aa5, 1'b0);
        add_row(OP_LHU, 32'h017, '0, 1'b0);
        add_row(OP_LH, 32'h013, '0, 1'b0);
        add_row(OP_LW, 32'h016, '0, 1'b0);
        add_row(OP_SW, 32'h02e, 32'h89ab_cdef, 1'b0);
        add_row(OP_LH, 32'h02f, '0, 1'b0);
        add_row(OP_LHU, 32'h031, '0, 1'b0);
        add_row(OP_LW, 32'h02d, '0, 1'b0);
        add_row(OP_LW, 32'h02b, '0, 1'b0);

        // Register block
        add_row(OP_SW, MMIO_BASE + SEG_OFFSET, 32'hdead_beef, 1'b0);
        add_row(OP_LW, MMIO_BASE + SEG_OFFSET, '0, 1'b0);
        add_row(OP_SW, MMIO_BASE + UART_DATA_OFFSET, 32'h0000_01a5, 1'b0);
        add_row(OP_LW, MMIO_BASE + UART_DATA_OFFSET, '0, 1'b0);
        add_row(OP_SW, MMIO_BASE + UART_DATA_OFFSET, 32'h0000_00ff, 1'b1);
        add_row(OP_LW, MMIO_BASE + UART_STATUS_OFFSET, '0, 1'b1);
        add_row(OP_LW, MMIO_BASE + UART_STATUS_OFFSET, '0, 1'b0);
        add_row(OP_LW, MMIO_BASE + UART_DATA_OFFSET, '0, 1'b0);

        // RAM words sharing the register offsets keep their contents
        add_row(OP_LW, 32'h000, '0, 1'b0);
        add_row(OP_LW, 32'h004, '0, 1'b0);
        add_row(OP_LW, 32'h008, '0, 1'b0);

        foreach (table_q[i]) run_request(table_q[i]);

        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
mem_pkg.sv
lane_bus_if.sv
mem_sequencer.sv
lane_encoder.sv
byte_lane_ram.sv
load_decoder.sv
mmio_regs.sv
memory_system.sv
tb_memory_system.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_memory_system -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

output=$(./obj_dir/Vtb_memory_system 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
